//--- verilog/cache_mem_pkg.sv
// Shared definitions for the cache storage block.
// Holds the per-cycle operation encoding, the default geometry and the
// width helpers that every module uses to size its ports.
// Modules pull it in with a wildcard import in their header.

`default_nettype none

package cache_mem_pkg;

  //////////////////////////////////////////////////////////////////////
  // operation sampled in a cycle
  typedef enum logic [2:0] {
    op_idle   = 3'd0,
    op_lookup = 3'd1,
    op_fill   = 3'd2,
    op_store  = 3'd3,
    op_evict  = 3'd4,
    op_flush  = 3'd5
  } cache_op_e;

  //////////////////////////////////////////////////////////////////////
  // default geometry, overridden from the top
  localparam int CACHE_XLEN       = 32;   // core word
  localparam int CACHE_PLEN       = 34;   // physical address
  localparam int CACHE_BLOCK_BITS = 128;  // one line
  localparam int CACHE_WAYS       = 2;
  localparam int CACHE_SETS       = 16;

  //////////////////////////////////////////////////////////////////////
  // width helpers
  function automatic int idx_bits(input int sets);
    return $clog2(sets);
  endfunction

  // byte offset inside a line
  function automatic int offs_bits(input int block_bits);
    return $clog2(block_bits / 8);
  endfunction

  // word select inside a line, never zero wide
  function automatic int word_offs_bits(input int xlen, input int block_bits);
    return (block_bits > xlen) ? $clog2(block_bits / xlen) : 1;
  endfunction

  function automatic int tag_bits(input int plen, input int sets, input int block_bits);
    return plen - idx_bits(sets) - offs_bits(block_bits);
  endfunction

endpackage

`default_nettype wire

//--- verilog/cache_sram_1rw.sv
// Single-port synchronous RAM, one per way for the tag and data arrays.
// Read-first: dout_o shows the old word one cycle after the address,
// also in a write cycle. Writes are masked per byte by be_i.

`default_nettype none

module cache_sram_1rw #(
  parameter  int ABITS = 4,
  parameter  int DBITS = 32,
  localparam int BBITS = (DBITS + 7) / 8   // last byte may be partial
) (
  input  wire logic             clk_i,
  input  wire logic [ABITS-1:0] addr_i,
  input  wire logic             we_i,
  input  wire logic [BBITS-1:0] be_i,
  input  wire logic [DBITS-1:0] din_i,
  output logic      [DBITS-1:0] dout_o
);

  logic [DBITS-1:0] mem [2**ABITS];  // no reset, contents undefined at start

  always_ff @(posedge clk_i)
  begin
    if (we_i)
    begin
      // bit loop so a partial top byte needs no special case
      for (int i = 0; i < DBITS; i++)
      begin
        if (be_i[i/8]) mem[addr_i][i] <= din_i[i];
      end
    end
    dout_o <= mem[addr_i];  // old data, read-first
  end

  //////////////////////////////////////////////////////////////////////
  // a write to an unknown address would corrupt the whole array
  a_wr_addr_known : assert property (
    @(posedge clk_i) we_i |-> !$isunknown(addr_i)
  ) else $error("sram write with unknown address %h", addr_i);

endmodule

`default_nettype wire

//--- verilog/cache_access_ctrl.sv
// Access control for the cache storage block.
// Turns the one-hot command pulses into an operation code, picks the
// array index, forms per-way write enables and the line byte enables,
// and holds the stage-1 copy of op and index for the arrays.

`default_nettype none

module cache_access_ctrl
  import cache_mem_pkg::*;
#(
  parameter  int XLEN       = CACHE_XLEN,
  parameter  int BLOCK_BITS = CACHE_BLOCK_BITS,
  parameter  int WAYS       = CACHE_WAYS,
  parameter  int SETS       = CACHE_SETS,
  localparam int IDX        = idx_bits(SETS),
  localparam int WOFFS      = word_offs_bits(XLEN, BLOCK_BITS),
  localparam int BLK_BE     = BLOCK_BITS / 8,
  localparam int WRD_BE     = XLEN / 8
) (
  input  wire logic              clk_i,
  input  wire logic              rst_ni,
  input  wire logic              lookup_i,
  input  wire logic              fill_i,
  input  wire logic              store_i,
  input  wire logic              evict_i,
  input  wire logic              flush_i,
  input  wire logic [IDX-1:0]    lookup_idx_i,
  input  wire logic [IDX-1:0]    fill_idx_i,
  input  wire logic [IDX-1:0]    store_idx_i,
  input  wire logic [IDX-1:0]    evict_idx_i,
  input  wire logic [WAYS-1:0]   fill_way_i,     // one-hot
  input  wire logic [WAYS-1:0]   store_ways_i,   // hit ways of the store
  input  wire logic [WOFFS-1:0]  store_offs_i,   // word within line
  input  wire logic [WRD_BE-1:0] store_be_i,
  output cache_op_e              op_o,           // this cycle
  output cache_op_e              op_q_o,         // stage 1
  output logic      [IDX-1:0]    idx_o,          // ram address
  output logic      [IDX-1:0]    idx_q_o,        // stage 1
  output logic      [WAYS-1:0]   tag_we_o,
  output logic      [WAYS-1:0]   dat_we_o,
  output logic      [WAYS-1:0]   dirty_we_o,
  output logic      [BLK_BE-1:0] blk_be_o
);

  logic [BLK_BE-1:0] store_blk_be;  // word enables moved to their slot

  //////////////////////////////////////////////////////////////////////
  // command decode and index select
  always_comb
  begin
    op_o  = op_idle;
    idx_o = lookup_idx_i;        // flush and idle do not care
    if (fill_i)
    begin
      op_o  = op_fill;
      idx_o = fill_idx_i;
    end
    else if (store_i)
    begin
      op_o  = op_store;
      idx_o = store_idx_i;
    end
    else if (evict_i)
    begin
      op_o  = op_evict;
      idx_o = evict_idx_i;
    end
    else if (flush_i) op_o = op_flush;
    else if (lookup_i) op_o = op_lookup;
  end

  // write enables, fill uses its way, store the ways that hit
  assign tag_we_o   = fill_i ? fill_way_i : '0;
  assign dat_we_o   = fill_i ? fill_way_i : (store_i ? store_ways_i : '0);
  assign dirty_we_o = dat_we_o;  // both write kinds update dirty

  // byte enables, store word placed at its offset, fill writes all
  assign store_blk_be = BLK_BE'(store_be_i) << (store_offs_i * WRD_BE);
  assign blk_be_o     = fill_i ? '1 : store_blk_be;

  //////////////////////////////////////////////////////////////////////
  // stage 1 register
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      op_q_o  <= op_idle;
      idx_q_o <= '0;
    end
    else
    begin
      op_q_o  <= op_o;
      idx_q_o <= idx_o;
    end
  end

  // the priority chain above relies on this
  a_one_cmd : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    $onehot0({lookup_i, fill_i, store_i, evict_i, flush_i})
  ) else $error("more than one command in a cycle");

endmodule

`default_nettype wire

//--- verilog/cache_tag_array.sv
// Tag side of the cache storage block.
// Tag RAM per way, valid and dirty bits in flip-flops, the stage-1 hit
// compare and the registered lookup flags and eviction address.
// way_hit_o goes to the data array for its output mux.

`default_nettype none

module cache_tag_array
  import cache_mem_pkg::*;
#(
  parameter  int PLEN       = CACHE_PLEN,
  parameter  int BLOCK_BITS = CACHE_BLOCK_BITS,
  parameter  int WAYS       = CACHE_WAYS,
  parameter  int SETS       = CACHE_SETS,
  localparam int IDX        = idx_bits(SETS),
  localparam int OFFS       = offs_bits(BLOCK_BITS),
  localparam int TAG        = tag_bits(PLEN, SETS, BLOCK_BITS)
) (
  input  wire logic            clk_i,
  input  wire logic            rst_ni,
  input  wire cache_op_e       op_i,
  input  wire cache_op_e       op_q_i,
  input  wire logic [IDX-1:0]  idx_i,
  input  wire logic [IDX-1:0]  idx_q_i,
  input  wire logic [WAYS-1:0] tag_we_i,
  input  wire logic [WAYS-1:0] dirty_we_i,
  input  wire logic [TAG-1:0]  fill_tag_i,
  input  wire logic            fill_dirty_i,
  input  wire logic [TAG-1:0]  lookup_tag_i,
  input  wire logic [WAYS-1:0] evict_way_i,    // one-hot
  input  wire logic            flush_i,
  output logic      [WAYS-1:0] way_hit_o,      // stage 1, unregistered
  output logic                 result_valid_o,
  output logic                 hit_o,
  output logic      [WAYS-1:0] ways_hit_o,
  output logic      [WAYS-1:0] ways_dirty_o,
  output logic                 cache_dirty_o,
  output logic                 evict_valid_o,
  output logic      [PLEN-1:0] evict_adr_o
);

  logic [WAYS-1:0][SETS-1:0] valid_q;
  logic [WAYS-1:0][SETS-1:0] dirty_q;
  logic [TAG-1:0]            tag_dout [WAYS];
  logic                      dirty_val;       // value written on dirty_we
  logic [TAG-1:0]            lookup_tag_q;    // aligned with ram output
  logic [WAYS-1:0]           evict_way_q;
  logic [WAYS-1:0]           way_dirty;
  logic [TAG-1:0]            victim_tag;
  logic [TAG-1:0]            evict_tag_q;
  logic [IDX-1:0]            evict_idx_q;

  //////////////////////////////////////////////////////////////////////
  // storage
  assign dirty_val = (op_i == op_fill) ? fill_dirty_i : 1'b1;  // store marks dirty

  for (genvar w = 0; w < WAYS; w++)
  begin : g_way
    cache_sram_1rw #(
      .ABITS  (IDX),
      .DBITS  (TAG)
    ) u_tag_ram (
      .clk_i  (clk_i),
      .addr_i (idx_i),
      .we_i   (tag_we_i[w]),
      .be_i   ('1),            // whole tag every time
      .din_i  (fill_tag_i),
      .dout_o (tag_dout[w])
    );

    // flush wins over a fill in the same cycle, never both anyway
    always_ff @(posedge clk_i or negedge rst_ni)
    begin
      if (!rst_ni)
      begin
        valid_q[w] <= '0;
        dirty_q[w] <= '0;
      end
      else
      begin
        if (flush_i) valid_q[w] <= '0;
        else if (tag_we_i[w]) valid_q[w][idx_i] <= 1'b1;
        if (dirty_we_i[w]) dirty_q[w][idx_i] <= dirty_val;
      end
    end

    // stage 1 compare
    assign way_hit_o[w] = valid_q[w][idx_q_i] & (tag_dout[w] == lookup_tag_q);
    assign way_dirty[w] = valid_q[w][idx_q_i] & dirty_q[w][idx_q_i];
  end

  // operands that travel alongside the ram read
  always_ff @(posedge clk_i)
  begin
    lookup_tag_q <= lookup_tag_i;
    evict_way_q  <= evict_way_i;
  end

  // victim tag, and/or select on one-hot way
  always_comb
  begin
    victim_tag = '0;
    for (int w = 0; w < WAYS; w++)
      victim_tag |= tag_dout[w] & {TAG{evict_way_q[w]}};
  end

  //////////////////////////////////////////////////////////////////////
  // result registers
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      result_valid_o <= 1'b0;
      evict_valid_o  <= 1'b0;
    end
    else
    begin
      result_valid_o <= (op_q_i == op_lookup);  // single-cycle pulse
      evict_valid_o  <= (op_q_i == op_evict);
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (op_q_i == op_lookup)
    begin
      hit_o         <= |way_hit_o;
      ways_hit_o    <= way_hit_o;
      ways_dirty_o  <= way_dirty;
      cache_dirty_o <= |(valid_q & dirty_q);  // only valid lines count
    end
    if (op_q_i == op_evict)
    begin
      evict_tag_q <= victim_tag;
      evict_idx_q <= idx_q_i;
    end
  end

  assign evict_adr_o = {evict_tag_q, evict_idx_q, {OFFS{1'b0}}};  // line aligned

  // a fill must land in exactly one way, checks the control decode
  a_fill_onehot : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (op_i == op_fill) |-> $onehot(tag_we_i)
  ) else $error("fill way not one-hot: %b", tag_we_i);

endmodule

`default_nettype wire

//--- verilog/cache_data_array.sv
// Data side of the cache storage block.
// One line-wide RAM per way, written by a line fill or a byte-masked
// store word. The hit vector from the tag side selects the lookup line
// and a delayed one-hot way selects the eviction line.

`default_nettype none

module cache_data_array
  import cache_mem_pkg::*;
#(
  parameter  int XLEN       = CACHE_XLEN,
  parameter  int BLOCK_BITS = CACHE_BLOCK_BITS,
  parameter  int WAYS       = CACHE_WAYS,
  parameter  int SETS       = CACHE_SETS,
  localparam int IDX        = idx_bits(SETS),
  localparam int BLK_BE     = BLOCK_BITS / 8
) (
  input  wire logic                  clk_i,
  input  wire logic                  rst_ni,
  input  wire cache_op_e             op_q_i,
  input  wire logic [IDX-1:0]        idx_i,
  input  wire logic [WAYS-1:0]       dat_we_i,
  input  wire logic [BLK_BE-1:0]     blk_be_i,
  input  wire logic                  fill_i,
  input  wire logic [BLOCK_BITS-1:0] fill_line_i,
  input  wire logic [XLEN-1:0]       store_data_i,
  input  wire logic [WAYS-1:0]       way_hit_i,     // stage 1
  input  wire logic [WAYS-1:0]       evict_way_i,   // one-hot
  output logic      [BLOCK_BITS-1:0] line_o,
  output logic      [BLOCK_BITS-1:0] evict_line_o
);

  logic [BLOCK_BITS-1:0] dat_in;
  logic [BLOCK_BITS-1:0] dat_dout [WAYS];
  logic [WAYS-1:0]       evict_way_q;
  logic [BLOCK_BITS-1:0] hit_line;    // zero on a miss
  logic [BLOCK_BITS-1:0] evict_line;

  // store word copied into every slot, byte enables pick the one
  assign dat_in = fill_i ? fill_line_i : {(BLOCK_BITS/XLEN){store_data_i}};

  for (genvar w = 0; w < WAYS; w++)
  begin : g_way
    cache_sram_1rw #(
      .ABITS  (IDX),
      .DBITS  (BLOCK_BITS)
    ) u_dat_ram (
      .clk_i  (clk_i),
      .addr_i (idx_i),
      .we_i   (dat_we_i[w]),
      .be_i   (blk_be_i),
      .din_i  (dat_in),
      .dout_o (dat_dout[w])
    );
  end

  // way select for the evict line, aligned with ram output
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni) evict_way_q <= '0;
    else         evict_way_q <= evict_way_i;
  end

  //////////////////////////////////////////////////////////////////////
  // and/or muxes, stage 1
  always_comb
  begin
    hit_line   = '0;
    evict_line = '0;
    for (int w = 0; w < WAYS; w++)
    begin
      hit_line   |= dat_dout[w] & {BLOCK_BITS{way_hit_i[w]}};
      evict_line |= dat_dout[w] & {BLOCK_BITS{evict_way_q[w]}};
    end
  end

  // output registers, loaded only by their own op
  always_ff @(posedge clk_i)
  begin
    if (op_q_i == op_lookup) line_o       <= hit_line;
    if (op_q_i == op_evict)  evict_line_o <= evict_line;
  end

endmodule

`default_nettype wire

//--- verilog/cache_mem_top.sv
// Top of the cache storage block.
// Connects access control, tag array and data array and sets the
// geometry for all of them. Commands are single-cycle pulses, results
// come back with result_valid_o or evict_valid_o two edges later.

`default_nettype none

module cache_mem_top
  import cache_mem_pkg::*;
#(
  parameter  int XLEN       = CACHE_XLEN,
  parameter  int PLEN       = CACHE_PLEN,
  parameter  int BLOCK_BITS = CACHE_BLOCK_BITS,
  parameter  int WAYS       = CACHE_WAYS,
  parameter  int SETS       = CACHE_SETS,
  localparam int IDX        = idx_bits(SETS),
  localparam int WOFFS      = word_offs_bits(XLEN, BLOCK_BITS),
  localparam int TAG        = tag_bits(PLEN, SETS, BLOCK_BITS)
) (
  input  wire logic                  clk_i,
  input  wire logic                  rst_ni,
  // lookup
  input  wire logic                  lookup_i,
  input  wire logic [IDX-1:0]        lookup_idx_i,
  input  wire logic [TAG-1:0]        lookup_tag_i,
  // line fill from the bus side
  input  wire logic                  fill_i,
  input  wire logic [IDX-1:0]        fill_idx_i,
  input  wire logic [TAG-1:0]        fill_tag_i,
  input  wire logic [WAYS-1:0]       fill_way_i,
  input  wire logic [BLOCK_BITS-1:0] fill_line_i,
  input  wire logic                  fill_dirty_i,
  // store merge
  input  wire logic                  store_i,
  input  wire logic [IDX-1:0]        store_idx_i,
  input  wire logic [WOFFS-1:0]      store_offs_i,
  input  wire logic [XLEN/8-1:0]     store_be_i,
  input  wire logic [XLEN-1:0]       store_data_i,
  input  wire logic [WAYS-1:0]       store_ways_i,
  // eviction and flush
  input  wire logic                  evict_i,
  input  wire logic [IDX-1:0]        evict_idx_i,
  input  wire logic [WAYS-1:0]       evict_way_i,
  input  wire logic                  flush_i,
  // results
  output logic                       result_valid_o,
  output logic                       hit_o,
  output logic      [WAYS-1:0]       ways_hit_o,
  output logic      [WAYS-1:0]       ways_dirty_o,
  output logic                       cache_dirty_o,
  output logic      [BLOCK_BITS-1:0] line_o,
  output logic                       evict_valid_o,
  output logic      [PLEN-1:0]       evict_adr_o,
  output logic      [BLOCK_BITS-1:0] evict_line_o
);

  cache_op_e                 op, op_q;
  logic [IDX-1:0]            idx, idx_q;
  logic [WAYS-1:0]           tag_we, dat_we, dirty_we;
  logic [BLOCK_BITS/8-1:0]   blk_be;
  logic [WAYS-1:0]           way_hit;    // tag side to data mux

  cache_access_ctrl #(
    .XLEN (XLEN), .BLOCK_BITS (BLOCK_BITS), .WAYS (WAYS), .SETS (SETS)
  ) u_ctrl (
    .clk_i, .rst_ni, .lookup_i, .fill_i, .store_i, .evict_i, .flush_i,
    .lookup_idx_i, .fill_idx_i, .store_idx_i, .evict_idx_i,
    .fill_way_i, .store_ways_i, .store_offs_i, .store_be_i,
    .op_o (op), .op_q_o (op_q), .idx_o (idx), .idx_q_o (idx_q),
    .tag_we_o (tag_we), .dat_we_o (dat_we), .dirty_we_o (dirty_we),
    .blk_be_o (blk_be)
  );

  cache_tag_array #(
    .PLEN (PLEN), .BLOCK_BITS (BLOCK_BITS), .WAYS (WAYS), .SETS (SETS)
  ) u_tag (
    .clk_i, .rst_ni, .op_i (op), .op_q_i (op_q), .idx_i (idx), .idx_q_i (idx_q),
    .tag_we_i (tag_we), .dirty_we_i (dirty_we), .fill_tag_i, .fill_dirty_i,
    .lookup_tag_i, .evict_way_i, .flush_i, .way_hit_o (way_hit),
    .result_valid_o, .hit_o, .ways_hit_o, .ways_dirty_o, .cache_dirty_o,
    .evict_valid_o, .evict_adr_o
  );

  cache_data_array #(
    .XLEN (XLEN), .BLOCK_BITS (BLOCK_BITS), .WAYS (WAYS), .SETS (SETS)
  ) u_data (
    .clk_i, .rst_ni, .op_q_i (op_q), .idx_i (idx), .dat_we_i (dat_we),
    .blk_be_i (blk_be), .fill_i, .fill_line_i, .store_data_i,
    .way_hit_i (way_hit), .evict_way_i, .line_o, .evict_line_o
  );

endmodule

`default_nettype wire

//--- dv/tb_cache_mem.sv
// Directed testbench for the cache storage block at default geometry.
// A reference model in arrays tracks tag, valid, dirty and line per way
// and set. Each test is a task that drives command pulses and checks
// the results at their fixed latency.

`default_nettype none

module tb_cache_mem
  import cache_mem_pkg::*;
();

  localparam int XLEN    = CACHE_XLEN;
  localparam int PLEN    = CACHE_PLEN;
  localparam int BB      = CACHE_BLOCK_BITS;
  localparam int WAYS    = CACHE_WAYS;
  localparam int SETS    = CACHE_SETS;
  localparam int IDX     = idx_bits(SETS);
  localparam int OFFS    = offs_bits(BB);
  localparam int WOFFS   = word_offs_bits(XLEN, BB);
  localparam int TAG     = tag_bits(PLEN, SETS, BB);
  localparam int N_TESTS = 6;

  logic clk_i, rst_ni;
  logic lookup_i, fill_i, store_i, evict_i, flush_i, fill_dirty_i;
  logic [IDX-1:0] lookup_idx_i, fill_idx_i, store_idx_i, evict_idx_i;
  logic [TAG-1:0] lookup_tag_i, fill_tag_i;
  logic [WAYS-1:0] fill_way_i, store_ways_i, evict_way_i;
  logic [BB-1:0] fill_line_i;
  logic [WOFFS-1:0] store_offs_i;
  logic [XLEN/8-1:0] store_be_i;
  logic [XLEN-1:0] store_data_i;
  logic result_valid_o, hit_o, cache_dirty_o, evict_valid_o;
  logic [WAYS-1:0] ways_hit_o, ways_dirty_o;
  logic [BB-1:0] line_o, evict_line_o;
  logic [PLEN-1:0] evict_adr_o;

  // reference model
  logic [TAG-1:0] m_tag [WAYS][SETS];
  logic [BB-1:0]  m_line [WAYS][SETS];
  bit             m_valid [WAYS][SETS];
  bit             m_dirty [WAYS][SETS];
  logic [31:0]    rng = 32'hb8a3_7099;

  cache_mem_top dut_i (.*);

  initial
  begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;  // period 4
  end

  //////////////////////////////////////////////////////////////////////
  // helpers
  function automatic logic [31:0] xorshift(input logic [31:0] x);
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    return x;
  endfunction

  function automatic logic [31:0] next_rand();
    rng = xorshift(rng);
    return rng;
  endfunction

  function automatic logic [BB-1:0] rand_line();
    logic [BB-1:0] l;
    for (int i = 0; i < BB / 32; i++)
      l[i*32 +: 32] = next_rand();
    return l;
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TEST RESULT: FAIL");
    $fatal(1);
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
      $display("ERR %s got %h exp %h", name, got, exp);
      abort_run("flag mismatch");
    end
  endtask

  task automatic check_ways(input string name, input logic [WAYS-1:0] got,
                            input logic [WAYS-1:0] exp);
    if (got !== exp)
    begin
      $display("ERR %s got %h exp %h", name, got, exp);
      abort_run("way vector mismatch");
    end
  endtask

  task automatic check_line(input string name, input logic [BB-1:0] got,
                            input logic [BB-1:0] exp);
    if (got !== exp)
    begin
      $display("ERR %s got %h exp %h", name, got, exp);
      abort_run("line mismatch");
    end
  endtask

  task automatic check_adr(input string name, input logic [PLEN-1:0] got,
                           input logic [PLEN-1:0] exp);
    if (got !== exp)
    begin
      $display("ERR %s got %h exp %h", name, got, exp);
      abort_run("address mismatch");
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // drive, one edge per step, pulses dropped after the edge
  task automatic step();
    @(posedge clk_i);
    #1;
    lookup_i = 1'b0;
    fill_i   = 1'b0;
    store_i  = 1'b0;
    evict_i  = 1'b0;
    flush_i  = 1'b0;
  endtask

  task automatic drive_lookup(input logic [IDX-1:0] idx, input logic [TAG-1:0] tag);
    lookup_i     = 1'b1;
    lookup_idx_i = idx;
    lookup_tag_i = tag;
  endtask

  task automatic drive_evict(input logic [IDX-1:0] idx, input int way);
    evict_i     = 1'b1;
    evict_idx_i = idx;
    evict_way_i = WAYS'(1) << way;
  endtask

  task automatic fill_way(input logic [IDX-1:0] idx, input int way, input bit dirty);
    fill_i       = 1'b1;
    fill_idx_i   = idx;
    fill_way_i   = WAYS'(1) << way;
    fill_tag_i   = {(TAG-1)'(next_rand()), way[0]};  // ways never share a tag
    fill_line_i  = rand_line();
    fill_dirty_i = dirty;
    m_tag[way][idx]   = fill_tag_i;
    m_line[way][idx]  = fill_line_i;
    m_valid[way][idx] = 1'b1;
    m_dirty[way][idx] = dirty;
    step();
  endtask

  // lookup result against the model, at the cycle of the pulse
  task automatic expect_lookup(input logic [IDX-1:0] idx, input logic [TAG-1:0] tag);
    logic [WAYS-1:0] hit_v;
    logic [WAYS-1:0] dirty_v;
    logic [BB-1:0]   line;
    logic            cd;
    hit_v = '0;
    dirty_v = '0;
    line = '0;
    cd = 1'b0;
    for (int w = 0; w < WAYS; w++)
    begin
      for (int s = 0; s < SETS; s++)
        cd |= m_valid[w][s] & m_dirty[w][s];  // invalid lines never dirty
      if (m_valid[w][idx] && m_tag[w][idx] == tag)
      begin
        hit_v[w] = 1'b1;
        line |= m_line[w][idx];
      end
      dirty_v[w] = m_valid[w][idx] & m_dirty[w][idx];
    end
    if (result_valid_o !== 1'b1)
      abort_run("result_valid_o did not pulse two edges after the lookup");
    check_bit("evict_valid_o", evict_valid_o, 1'b0);
    check_bit("hit_o", hit_o, |hit_v);
    check_ways("ways_hit_o", ways_hit_o, hit_v);
    check_ways("ways_dirty_o", ways_dirty_o, dirty_v);
    check_bit("cache_dirty_o", cache_dirty_o, cd);
    check_line("line_o", line_o, line);
  endtask

  task automatic expect_evict(input logic [IDX-1:0] idx, input int way);
    if (evict_valid_o !== 1'b1)
      abort_run("evict_valid_o did not pulse two edges after the evict");
    check_bit("result_valid_o", result_valid_o, 1'b0);
    check_adr("evict_adr_o", evict_adr_o, {m_tag[way][idx], idx, {OFFS{1'b0}}});
    check_line("evict_line_o", evict_line_o, m_line[way][idx]);
  endtask

  task automatic lookup_and_check(input logic [IDX-1:0] idx, input logic [TAG-1:0] tag);
    drive_lookup(idx, tag);
    step();
    check_bit("result_valid_o", result_valid_o, 1'b0);  // not early
    step();
    expect_lookup(idx, tag);
    step();
    check_bit("result_valid_o", result_valid_o, 1'b0);  // one cycle only
  endtask

  //////////////////////////////////////////////////////////////////////
  // directed tests
  task automatic test_reset_miss();
    for (int s = 0; s < SETS; s++)
      lookup_and_check(IDX'(s), TAG'(next_rand()));
  endtask

  task automatic test_fill_hit();
    for (int s = 0; s < 4; s++)
      for (int w = 0; w < WAYS; w++)
        fill_way(IDX'(s), w, 1'(next_rand()));
    for (int s = 0; s < 4; s++)
    begin
      for (int w = 0; w < WAYS; w++)
        lookup_and_check(IDX'(s), m_tag[w][s]);
      lookup_and_check(IDX'(s), m_tag[0][s] ^ TAG'(2));  // bit 0 keeps it off way 1
    end
  endtask

  task automatic test_store_merge();
    logic [IDX-1:0] s;
    int             w;
    for (int k = 0; k < 6; k++)
    begin
      s = IDX'(next_rand() % 4);
      w = next_rand() % WAYS;
      store_i      = 1'b1;
      store_idx_i  = s;
      store_ways_i = WAYS'(1) << w;
      store_offs_i = WOFFS'(next_rand());
      store_be_i   = (XLEN/8)'(next_rand());
      store_data_i = XLEN'(next_rand());
      for (int b = 0; b < XLEN / 8; b++)
        if (store_be_i[b])
          m_line[w][s][store_offs_i*XLEN + b*8 +: 8] = store_data_i[b*8 +: 8];
      m_dirty[w][s] = 1'b1;
      step();
      lookup_and_check(s, m_tag[w][s]);
    end
  endtask

  task automatic test_evict();
    for (int s = 0; s < 4; s++)
      for (int w = 0; w < WAYS; w++)
      begin
        drive_evict(IDX'(s), w);
        step();
        check_bit("evict_valid_o", evict_valid_o, 1'b0);
        step();
        expect_evict(IDX'(s), w);
        step();
        check_bit("evict_valid_o", evict_valid_o, 1'b0);
      end
  endtask

  // one command per cycle, each result two cycles after its issue
  task automatic test_pipeline();
    logic [IDX-1:0] p_idx [6];
    logic [TAG-1:0] p_tag [6];
    bit             p_ev  [6];
    int             p_way [6];
    p_idx = '{0, 1, 0, 2, 3, 3};
    p_ev  = '{0, 0, 1, 0, 0, 1};
    p_way = '{0, 1, 1, 0, 0, 0};
    for (int i = 0; i < 6; i++)
      p_tag[i] = m_tag[p_way[i]][p_idx[i]];
    p_tag[3] = m_tag[0][2] ^ TAG'(2);  // a miss in the middle
    for (int i = 0; i < 8; i++)
    begin
      if (i < 2)
      begin
        check_bit("result_valid_o", result_valid_o, 1'b0);
        check_bit("evict_valid_o", evict_valid_o, 1'b0);
      end
      else if (p_ev[i-2]) expect_evict(p_idx[i-2], p_way[i-2]);
      else expect_lookup(p_idx[i-2], p_tag[i-2]);
      if (i < 6)
      begin
        if (p_ev[i]) drive_evict(p_idx[i], p_way[i]);
        else drive_lookup(p_idx[i], p_tag[i]);
      end
      step();
    end
    check_bit("result_valid_o", result_valid_o, 1'b0);
    check_bit("evict_valid_o", evict_valid_o, 1'b0);
  endtask

  task automatic test_flush();
    flush_i = 1'b1;
    for (int w = 0; w < WAYS; w++)
      for (int s = 0; s < SETS; s++)
        m_valid[w][s] = 1'b0;
    step();
    for (int s = 0; s < 4; s++)
      for (int w = 0; w < WAYS; w++)
        lookup_and_check(IDX'(s), m_tag[w][s]);  // all miss, not dirty
    fill_way(IDX'(0), 0, 1'b1);
    lookup_and_check(IDX'(0), m_tag[0][0]);
  endtask

  //////////////////////////////////////////////////////////////////////
  // main sequence and watchdog
  initial
  begin
    rst_ni = 1'b0;
    {lookup_i, fill_i, store_i, evict_i, flush_i, fill_dirty_i} = '0;
    {lookup_idx_i, fill_idx_i, store_idx_i, evict_idx_i} = '0;
    {lookup_tag_i, fill_tag_i, fill_way_i, store_ways_i, evict_way_i} = '0;
    {fill_line_i, store_offs_i, store_be_i, store_data_i} = '0;
    repeat (10) @(posedge clk_i);
    #1 rst_ni = 1'b1;
    check_bit("result_valid_o", result_valid_o, 1'b0);
    check_bit("evict_valid_o", evict_valid_o, 1'b0);
    test_reset_miss();
    test_fill_hit();
    test_store_merge();
    test_evict();
    test_pipeline();
    test_flush();
    $display("TEST RESULT: PASS");
    $finish;
  end

  initial
  begin
    repeat (N_TESTS * 200) @(posedge clk_i);
    abort_run("watchdog expired before the tests finished");
  end

endmodule

`default_nettype wire

//--- filelist.f
verilog/cache_mem_pkg.sv
verilog/cache_sram_1rw.sv
verilog/cache_access_ctrl.sv
verilog/cache_tag_array.sv
verilog/cache_data_array.sv
verilog/cache_mem_top.sv
dv/tb_cache_mem.sv
